/* Bender.yml */
package:
  name: mem_ctl

sources:
  - verilog/microwordPkg.sv
  - verilog/memRefPkg.sv
  - verilog/memFuncDecode.sv
  - verilog/refTypeReg.sv
  - verilog/vmaContext.sv
  - verilog/pxctControl.sv
  - verilog/heldStatus.sv
  - verilog/memCtl.sv
  - target: simulation
    files:
      - verification/memCtl_chk.sv
      - verification/memCtlCheck.sv
      - verification/memCtlTb.sv

/* compile.f */
verilog/microwordPkg.sv
verilog/memRefPkg.sv
verilog/memFuncDecode.sv
verilog/refTypeReg.sv
verilog/vmaContext.sv
verilog/pxctControl.sv
verilog/heldStatus.sv
verilog/memCtl.sv
verification/memCtl_chk.sv
verification/memCtlCheck.sv
verification/memCtlTb.sv

/* verification/memCtlCheck.sv */
`timescale 1ns/1ps

module memCtlCheck (
  input  logic                                  clk,
  input  logic                                  arstN,
  input  logic [microwordPkg::memFuncWidth-1:0] memFunc,
  input  microwordPkg::magicWord                magic,
  input  logic [microwordPkg::vmaLoadWidth-1:0] vmaLoad,
  input  logic [2:0]                            dramA,
  input  logic                                  testSatisfied,
  input  logic                                  pcUser,
  input  logic                                  pcPublic,
  input  logic                                  loadSpecInstr,
  input  logic [9:12]                           acField,
  input  logic [5:12]                           adHigh,
  input  logic                                  condSelVma,
  input  logic [memRefPkg::heldWidth-1:0]       pcFlags,
  input  logic                                  trapEn,
  input  logic                                  cacheLoadEn,
  input  logic [memRefPkg::refTypeWidth-1:0]    refType,
  input  logic                                  vmaFetch,
  input  logic [memRefPkg::ctxWidth-1:0]        ctx,
  input  logic                                  adrErr,
  input  logic                                  mboxCycReq,
  input  logic [memRefPkg::heldWidth-1:0]       statusWord,
  output int                                    errorCount,
  output int                                    checkCount
);

  logic [3:0]  refModel;
  logic        fetchModel;
  logic [5:0]  ctxModel;
  logic        adrErrModel;
  logic        pxctFlagModel;
  logic [9:12] acModel;
  logic [11:0] heldModel;

  function automatic logic fetchRule(input logic [3:0] func, input microwordPkg::magicWord mg,
                                     input logic [2:0] mode, input logic test);
    fetchRule = (func == microwordPkg::memUncondFetch) ||
                (func == microwordPkg::memCondFetch && mg.specMemView.fetch && test) ||
                (func == microwordPkg::memARead && mode == 3'd1);
  endfunction

  function automatic logic [3:0] refTypeRule(input logic [3:0] func,
                                             input microwordPkg::magicWord mg,
                                             input logic [5:12] ad, input logic [2:0] mode,
                                             input logic test);
    logic [3:0] req;
    req = '0;
    if (func == microwordPkg::memEaCalc) begin
      req[memRefPkg::refLoadAr] = mg.eaCalcView.loadAr;
      req[memRefPkg::refLoadArx] = mg.eaCalcView.loadArx;
      req[memRefPkg::refPause] = mg.eaCalcView.pause;
      req[memRefPkg::refWrite] = mg.eaCalcView.write;
    end
    if (func == microwordPkg::memAdFunc) begin
      req[memRefPkg::refLoadAr] = ad[9];
      req[memRefPkg::refLoadArx] = ad[10];
      req[memRefPkg::refPause] = ad[11];
      req[memRefPkg::refWrite] = ad[12];
    end
    if (func inside {microwordPkg::memLoadAr, microwordPkg::memRwCycle,
                     microwordPkg::memRpwCycle})
      req[memRefPkg::refLoadAr] = 1'b1;
    if (func == microwordPkg::memLoadArx || fetchRule(func, mg, mode, test))
      req[memRefPkg::refLoadArx] = 1'b1;
    if (func == microwordPkg::memRpwCycle || (func == microwordPkg::memARead && mode == 3'd7))
      req[memRefPkg::refPause] = 1'b1;
    if (func inside {microwordPkg::memWrite, microwordPkg::memBWrite,
                     microwordPkg::memRwCycle, microwordPkg::memRpwCycle} ||
        (func == microwordPkg::memARead && mode inside {3'd3, 3'd6, 3'd7}))
      req[memRefPkg::refWrite] = 1'b1;
    refTypeRule = req;
  endfunction

  function automatic logic prevRule(input logic [3:0] func, input microwordPkg::magicWord mg,
                                    input logic flag, input logic [9:12] ac);
    logic [9:12] sel;
    sel = flag ? ac : 4'b0;
    prevRule = (func == microwordPkg::memARead && sel[10]) ||
               (func == microwordPkg::memEaCalc && mg.eaCalcView.previous && sel[12]) ||
               (func == microwordPkg::memEaCalc && mg.eaCalcView.prevIndex && sel[11]);
  endfunction

  function automatic logic [5:0] ctxRule(input logic [3:0] func, input microwordPkg::magicWord mg,
                                         input logic [5:12] ad, input logic prev);
    logic [5:0] c;
    logic       ea;
    logic       adf;
    ea = (func == microwordPkg::memEaCalc);
    adf = (func == microwordPkg::memAdFunc);
    c = '0;
    c[memRefPkg::ctxUser] = pcUser || (adf && ad[5]) || (ea && mg.eaCalcView.userCycle);
    c[memRefPkg::ctxPublic] = pcPublic || (adf && ad[6]) || (ea && mg.eaCalcView.userCycle);
    c[memRefPkg::ctxPrevious] = prev;
    c[memRefPkg::ctxExtended] = ea && mg.eaCalcView.extended;
    c[memRefPkg::ctxCache] = !cacheLoadEn;
    c[memRefPkg::ctxPaged] = trapEn;
    ctxRule = c;
  endfunction

  // Register functions hide user, public and previous
  function automatic logic [5:0] visibleCtx(input logic [5:0] c, input logic [3:0] func);
    visibleCtx = c;
    if (func == microwordPkg::memRegFunc) begin
      visibleCtx[memRefPkg::ctxUser] = 1'b0;
      visibleCtx[memRefPkg::ctxPublic] = 1'b0;
      visibleCtx[memRefPkg::ctxPrevious] = 1'b0;
    end
  endfunction

  function automatic logic [11:0] heldRule(input logic [3:0] rt, input logic [5:0] c,
                                           input logic f, input logic mapF);
    heldRule = {!c[memRefPkg::ctxPaged], !c[memRefPkg::ctxCache], mapF, f, c[3:0], rt};
  endfunction

  function automatic logic ctxLoadRule(input logic [3:0] func, input microwordPkg::magicWord mg,
                                       input logic [1:0] vl, input logic test);
    ctxLoadRule = (vl != 2'd0) &&
                  !(func == microwordPkg::memCondFetch && !(mg.specMemView.fetch && test));
  endfunction

  function automatic logic mboxRule(input logic [3:0] func, input logic [2:0] mode);
    mboxRule = func[3] || (func == microwordPkg::memARead && mode != 3'd0 && mode != 3'd2);
  endfunction

  always @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      refModel <= '0;
      fetchModel <= 1'b0;
      ctxModel <= '0;
      adrErrModel <= 1'b0;
      pxctFlagModel <= 1'b0;
      acModel <= '0;
      heldModel <= '0;
    end else begin
      if (memFunc[3] || memFunc inside {microwordPkg::memBWrite, microwordPkg::memARead,
                                        microwordPkg::memCondFetch}) begin
        refModel <= refTypeRule(memFunc, magic, adHigh, dramA, testSatisfied);
        fetchModel <= fetchRule(memFunc, magic, dramA, testSatisfied);
      end
      if (ctxLoadRule(memFunc, magic, vmaLoad, testSatisfied)) begin
        ctxModel <= ctxRule(memFunc, magic, adHigh,
                            prevRule(memFunc, magic, pxctFlagModel, acModel));
        adrErrModel <= (memFunc == microwordPkg::memEaCalc) && magic.eaCalcView.extended &&
                       (|adHigh[6:11]);
      end
      if (loadSpecInstr) begin
        pxctFlagModel <= magic.specMemView.pcPrev;
        acModel <= acField;
      end
      if (memFunc == microwordPkg::memARead || memFunc == microwordPkg::memWrite)
        heldModel <= heldRule(refModel, visibleCtx(ctxModel, memFunc), fetchModel,
                              memFunc == microwordPkg::memRegFunc);
    end
  end

  task automatic compareField(input string name, input logic [11:0] actual,
                              input logic [11:0] expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  // Outputs are settled at the falling edge
  always @(negedge clk) begin
    compareField("refType", 12'(refType), 12'(refModel));
    compareField("vmaFetch", 12'(vmaFetch), 12'(fetchModel));
    compareField("ctx", 12'(ctx), 12'(visibleCtx(ctxModel, memFunc)));
    compareField("adrErr", 12'(adrErr), 12'(adrErrModel));
    compareField("mboxCycReq", 12'(mboxCycReq), 12'(mboxRule(memFunc, dramA)));
    compareField("statusWord", statusWord, condSelVma ? heldModel : pcFlags);
  end

endmodule

/* verification/memCtlTb.sv */
`timescale 1ns/1ps

module memCtlTb;

  localparam int clkPeriodNs = 40;
  localparam int resetCycles = 16;
  localparam int randomWords = 400;
  localparam int directedCycles = 16 * 8 * 2;
  localparam int pxctCycles = 17 * 6;
  localparam int totalCycles = resetCycles + randomWords + directedCycles + pxctCycles + 4;

  logic                           clk;
  logic                           arstN;
  logic [3:0]                     memFunc;
  microwordPkg::magicWord         magic;
  logic [1:0]                     vmaLoad;
  logic [2:0]                     dramA;
  logic                           testSatisfied;
  logic                           pcUser;
  logic                           pcPublic;
  logic                           loadSpecInstr;
  logic [9:12]                    acField;
  logic [5:12]                    adHigh;
  logic                           condSelVma;
  logic [11:0]                    pcFlags;
  logic                           trapEn;
  logic                           cacheLoadEn;
  logic [3:0]                     refType;
  logic                           vmaFetch;
  logic [5:0]                     ctx;
  logic                           adrErr;
  logic                           mboxCycReq;
  logic [11:0]                    statusWord;
  int                             errorCount;
  int                             checkCount;

  memCtl memCtl_i (.*);

  memCtlCheck memCtlCheck_i (.*);

  bind memCtl memCtl_chk memCtl_chk_i (
    .clk        (clk),
    .arstN      (arstN),
    .reqEn      (reqEn),
    .condSelVma (condSelVma),
    .pcFlags    (pcFlags),
    .statusWord (statusWord),
    .refType    (refType),
    .vmaFetch   (vmaFetch),
    .ctx        (ctx),
    .adrErr     (adrErr)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriodNs / 2) clk = ~clk;
  end

  initial begin
    #(totalCycles * clkPeriodNs * 2);
    $display("Watchdog expired before the stimulus completed");
    $display("TEST FAILED");
    $finish;
  end

  // AD 6-11 clear half the time so adrErr goes both ways
  task automatic randomWord();
    memFunc <= 4'($urandom);
    magic <= 9'($urandom);
    vmaLoad <= 2'($urandom);
    dramA <= 3'($urandom);
    testSatisfied <= 1'($urandom);
    pcUser <= 1'($urandom);
    pcPublic <= 1'($urandom);
    loadSpecInstr <= ($urandom % 8) == 0;
    acField <= 4'($urandom);
    adHigh <= ($urandom % 2) ? 8'($urandom) : {1'($urandom), 6'b0, 1'($urandom)};
    condSelVma <= 1'($urandom);
    pcFlags <= 12'($urandom);
    trapEn <= 1'($urandom);
    cacheLoadEn <= 1'($urandom);
  endtask

  task automatic pxctStep(input logic [3:0] func, input logic [8:0] mg, input logic sel);
    @(posedge clk);
    randomWord();
    memFunc <= func;
    magic <= mg;
    vmaLoad <= 2'd3;
    loadSpecInstr <= 1'b0;
    condSelVma <= sel;
  endtask

  initial begin
    void'($urandom(32'h9966));
    arstN = 1'b0;
    memFunc = '0;
    magic = '0;
    vmaLoad = '0;
    dramA = '0;
    testSatisfied = 1'b0;
    pcUser = 1'b0;
    pcPublic = 1'b0;
    loadSpecInstr = 1'b0;
    acField = '0;
    adHigh = '0;
    condSelVma = 1'b1;
    pcFlags = 12'h5a3;
    trapEn = 1'b0;
    cacheLoadEn = 1'b0;
    // Flags differ from the cleared held word, so both sides of the mux show
    repeat (resetCycles) begin
      @(posedge clk);
      condSelVma <= ~condSelVma;
    end
    arstN <= 1'b1;

    repeat (randomWords) begin
      @(posedge clk);
      randomWord();
    end

    // Each code and addressing mode, then a look at the held word
    for (int f = 0; f < 16; f++) begin
      for (int m = 0; m < 8; m++) begin
        @(posedge clk);
        randomWord();
        memFunc <= 4'(f);
        dramA <= 3'(m);
        vmaLoad <= 2'(1 + m % 3);
        testSatisfied <= 1'(m);
        condSelVma <= 1'b0;
        @(posedge clk);
        randomWord();
        memFunc <= microwordPkg::memNone;
        condSelVma <= 1'b1;
      end
    end

    // Every AC value with the PXCT flag set, then all AC bits with it clear
    for (int ac = 0; ac < 17; ac++) begin
      @(posedge clk);
      randomWord();
      memFunc <= microwordPkg::memNone;
      loadSpecInstr <= 1'b1;
      magic <= (ac < 16) ? 9'h040 : 9'h000;
      acField <= (ac < 16) ? 4'(ac) : 4'hf;
      pxctStep(microwordPkg::memARead, 9'h000, 1'b0);
      pxctStep(microwordPkg::memEaCalc, 9'h040, 1'b0);
      pxctStep(microwordPkg::memEaCalc, 9'h100, 1'b0);
      pxctStep(microwordPkg::memRegFunc, 9'h000, 1'b0);
      pxctStep(microwordPkg::memNone, 9'h000, 1'b1);
    end

    repeat (2) @(posedge clk);
    @(negedge clk);
    $display("Closing report: %0d compares, %0d compare errors, %0d assertion failures",
             checkCount, errorCount, memCtl_i.memCtl_chk_i.assertFails);
    if (errorCount == 0 && memCtl_i.memCtl_chk_i.assertFails == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* verification/memCtl_chk.sv */
`timescale 1ns/1ps

module memCtl_chk (
  input logic                               clk,
  input logic                               arstN,
  input logic                               reqEn,
  input logic                               condSelVma,
  input logic [memRefPkg::heldWidth-1:0]    pcFlags,
  input logic [memRefPkg::heldWidth-1:0]    statusWord,
  input logic [memRefPkg::refTypeWidth-1:0] refType,
  input logic                               vmaFetch,
  input logic [memRefPkg::ctxWidth-1:0]     ctx,
  input logic                               adrErr
);

  int assertFails;

  // Held word is only visible through statusWord
  resetClear: assert property (@(posedge clk)
    !arstN |-> (refType == '0 && !vmaFetch && ctx == '0 && !adrErr &&
                (!condSelVma || statusWord == '0)))
    else begin
      assertFails++;
      $error("registers not cleared while reset is active");
    end

  refTypeHold: assert property (@(posedge clk) disable iff (!arstN)
    !reqEn |=> $stable(refType))
    else begin
      assertFails++;
      $error("refType changed without a request enable");
    end

  flagsPassThrough: assert property (@(posedge clk)
    !condSelVma |-> statusWord == pcFlags)
    else begin
      assertFails++;
      $error("statusWord differs from pcFlags while condSelVma is low");
    end

endmodule

/* verilog/heldStatus.sv */
`timescale 1ns/1ps

module heldStatus (
  input  logic                                clk,
  input  logic                                arstN,
  input  logic                                loadVmaHeld,
  input  logic [memRefPkg::refTypeWidth-1:0]  refType,
  input  logic [memRefPkg::ctxWidth-1:0]      ctx,
  input  logic                                vmaFetch,
  input  logic                                regFunc,
  input  logic                                condSelVma,
  input  logic [memRefPkg::heldWidth-1:0]     pcFlags,
  output logic [memRefPkg::heldWidth-1:0]     statusWord
);

  logic [memRefPkg::heldWidth-1:0] heldNext;
  logic [memRefPkg::heldWidth-1:0] heldReg;

  always_comb begin
    heldNext = '0;
    heldNext[memRefPkg::heldRefLsb +: memRefPkg::refTypeWidth] = refType;
    heldNext[memRefPkg::heldCtxLsb +: memRefPkg::heldCtxWidth] =
      ctx[memRefPkg::heldCtxWidth-1:0];
    heldNext[memRefPkg::heldFetch] = vmaFetch;
    heldNext[memRefPkg::heldMapFunc] = regFunc;
    heldNext[memRefPkg::heldNotCache] = ~ctx[memRefPkg::ctxCache];
    heldNext[memRefPkg::heldNotPaged] = ~ctx[memRefPkg::ctxPaged];
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      heldReg <= '0;
    end else if (loadVmaHeld) begin
      heldReg <= heldNext;
    end
  end

  // Same status lines carry either the last reference or the PC flags
  assign statusWord = condSelVma ? heldReg : pcFlags;

endmodule

/* verilog/memCtl.sv */
`timescale 1ns/1ps

module memCtl (
  input  logic                                  clk,
  input  logic                                  arstN,
  input  logic [microwordPkg::memFuncWidth-1:0] memFunc,
  input  microwordPkg::magicWord                magic,
  input  logic [microwordPkg::vmaLoadWidth-1:0] vmaLoad,
  input  logic [2:0]                            dramA,
  input  logic                                  testSatisfied,
  input  logic                                  pcUser,
  input  logic                                  pcPublic,
  input  logic                                  loadSpecInstr,
  input  logic [9:12]                           acField,
  input  logic [5:12]                           adHigh,
  input  logic                                  condSelVma,
  input  logic [memRefPkg::heldWidth-1:0]       pcFlags,
  input  logic                                  trapEn,
  input  logic                                  cacheLoadEn,
  output logic [memRefPkg::refTypeWidth-1:0]    refType,
  output logic                                  vmaFetch,
  output logic [memRefPkg::ctxWidth-1:0]        ctx,
  output logic                                  adrErr,
  output logic                                  mboxCycReq,
  output logic [memRefPkg::heldWidth-1:0]       statusWord
);

  logic eaCalc;
  logic adFunc;
  logic aRead;
  logic regFunc;
  logic bWrite;
  logic rwCycle;
  logic rpwCycle;
  logic writeFunc;
  logic loadArFunc;
  logic loadArxFunc;
  logic uncondFetch;
  logic condFetchTaken;
  logic reqEn;
  logic loadVmaContext;
  logic loadVmaHeld;
  logic prevEn;

  memFuncDecode memFuncDecode_i (
    .memFunc        (memFunc),
    .magic          (magic),
    .vmaLoad        (vmaLoad),
    .dramA          (dramA),
    .testSatisfied  (testSatisfied),
    .eaCalc         (eaCalc),
    .adFunc         (adFunc),
    .aRead          (aRead),
    .regFunc        (regFunc),
    .bWrite         (bWrite),
    .rwCycle        (rwCycle),
    .rpwCycle       (rpwCycle),
    .writeFunc      (writeFunc),
    .loadArFunc     (loadArFunc),
    .loadArxFunc    (loadArxFunc),
    .uncondFetch    (uncondFetch),
    .condFetchTaken (condFetchTaken),
    .reqEn          (reqEn),
    .loadVmaContext (loadVmaContext),
    .loadVmaHeld    (loadVmaHeld),
    .mboxCycReq     (mboxCycReq)
  );

  refTypeReg refTypeReg_i (
    .clk            (clk),
    .arstN          (arstN),
    .reqEn          (reqEn),
    .eaCalc         (eaCalc),
    .adFunc         (adFunc),
    .aRead          (aRead),
    .bWrite         (bWrite),
    .rwCycle        (rwCycle),
    .rpwCycle       (rpwCycle),
    .writeFunc      (writeFunc),
    .loadArFunc     (loadArFunc),
    .loadArxFunc    (loadArxFunc),
    .uncondFetch    (uncondFetch),
    .condFetchTaken (condFetchTaken),
    .magic          (magic),
    .adHigh         (adHigh),
    .dramA          (dramA),
    .refType        (refType),
    .vmaFetch       (vmaFetch)
  );

  vmaContext vmaContext_i (
    .clk            (clk),
    .arstN          (arstN),
    .loadVmaContext (loadVmaContext),
    .eaCalc         (eaCalc),
    .adFunc         (adFunc),
    .regFunc        (regFunc),
    .magic          (magic),
    .adHigh         (adHigh),
    .pcUser         (pcUser),
    .pcPublic       (pcPublic),
    .trapEn         (trapEn),
    .cacheLoadEn    (cacheLoadEn),
    .prevEn         (prevEn),
    .ctx            (ctx),
    .adrErr         (adrErr)
  );

  pxctControl pxctControl_i (
    .clk           (clk),
    .arstN         (arstN),
    .loadSpecInstr (loadSpecInstr),
    .magic         (magic),
    .acField       (acField),
    .eaCalc        (eaCalc),
    .aRead         (aRead),
    .prevEn        (prevEn)
  );

  heldStatus heldStatus_i (
    .clk         (clk),
    .arstN       (arstN),
    .loadVmaHeld (loadVmaHeld),
    .refType     (refType),
    .ctx         (ctx),
    .vmaFetch    (vmaFetch),
    .regFunc     (regFunc),
    .condSelVma  (condSelVma),
    .pcFlags     (pcFlags),
    .statusWord  (statusWord)
  );

endmodule

/* verilog/memFuncDecode.sv */
`timescale 1ns/1ps

module memFuncDecode (
  input  logic [microwordPkg::memFuncWidth-1:0] memFunc,
  input  microwordPkg::magicWord                magic,
  input  logic [microwordPkg::vmaLoadWidth-1:0] vmaLoad,
  input  logic [2:0]                            dramA,
  input  logic                                  testSatisfied,
  output logic                                  eaCalc,
  output logic                                  adFunc,
  output logic                                  aRead,
  output logic                                  regFunc,
  output logic                                  bWrite,
  output logic                                  rwCycle,
  output logic                                  rpwCycle,
  output logic                                  writeFunc,
  output logic                                  loadArFunc,
  output logic                                  loadArxFunc,
  output logic                                  uncondFetch,
  output logic                                  condFetchTaken,
  output logic                                  reqEn,
  output logic                                  loadVmaContext,
  output logic                                  loadVmaHeld,
  output logic                                  mboxCycReq
);

  localparam int groupSize = 2 ** (microwordPkg::memFuncWidth - 1);

  logic [groupSize-1:0]   regGroup;
  logic [groupSize-1:0]   cycGroup;
  logic [2*groupSize-1:0] funcHot;
  logic                   condFetch;
  logic                   condFetchFailed;

  // One 3-to-8 decoder per half of the code space
  function automatic logic [groupSize-1:0] groupDecode(
    input logic                                  en,
    input logic [microwordPkg::memFuncWidth-2:0] sel
  );
    groupDecode = en ? groupSize'(1) << sel : '0;
  endfunction

  assign regGroup = groupDecode(~memFunc[microwordPkg::memFuncWidth-1],
                                memFunc[microwordPkg::memFuncWidth-2:0]);
  assign cycGroup = groupDecode(memFunc[microwordPkg::memFuncWidth-1],
                                memFunc[microwordPkg::memFuncWidth-2:0]);
  assign funcHot = {cycGroup, regGroup};

  assign aRead = funcHot[microwordPkg::memARead];
  assign bWrite = funcHot[microwordPkg::memBWrite];
  assign condFetch = funcHot[microwordPkg::memCondFetch];
  assign regFunc = funcHot[microwordPkg::memRegFunc];
  assign adFunc = funcHot[microwordPkg::memAdFunc];
  assign eaCalc = funcHot[microwordPkg::memEaCalc];
  assign loadArFunc = funcHot[microwordPkg::memLoadAr];
  assign loadArxFunc = funcHot[microwordPkg::memLoadArx];
  assign rwCycle = funcHot[microwordPkg::memRwCycle];
  assign rpwCycle = funcHot[microwordPkg::memRpwCycle];
  assign writeFunc = funcHot[microwordPkg::memWrite];
  assign uncondFetch = funcHot[microwordPkg::memUncondFetch];

  // Conditional fetch needs both the magic fetch bit and a passing test
  assign condFetchTaken = condFetch & magic.specMemView.fetch & testSatisfied;
  assign condFetchFailed = condFetch & ~condFetchTaken;

  // A-read and conditional fetch also set type and fetch state
  assign reqEn = (|cycGroup) | bWrite | aRead | condFetch;
  assign loadVmaContext = (|vmaLoad) & ~condFetchFailed;
  assign loadVmaHeld = aRead | writeFunc;

  // No MBOX cycle for immediate A modes 0 and 2
  assign mboxCycReq = (|cycGroup) | (aRead & (dramA != 3'd0) & (dramA != 3'd2));

endmodule

/* verilog/memRefPkg.sv */
package memRefPkg;

  // Reference type word
  localparam int refTypeWidth = 4;
  localparam int refLoadAr = 0;
  localparam int refLoadArx = 1;
  localparam int refPause = 2;
  localparam int refWrite = 3;

  // Context word, low four bits go into the held word
  localparam int ctxWidth = 6;
  localparam int ctxUser = 0;
  localparam int ctxPublic = 1;
  localparam int ctxPrevious = 2;
  localparam int ctxExtended = 3;
  localparam int ctxCache = 4;
  localparam int ctxPaged = 5;

  // Held status word
  localparam int heldWidth = 12;
  localparam int heldRefLsb = 0;
  localparam int heldCtxLsb = 4;
  localparam int heldFetch = 8;
  localparam int heldMapFunc = 9;
  localparam int heldNotCache = 10;
  localparam int heldNotPaged = 11;

  // Context bits copied into the held word
  localparam int heldCtxWidth = 4;

endpackage

/* verilog/microwordPkg.sv */
package microwordPkg;

  // Microword field widths
  localparam int memFuncWidth = 4;
  localparam int magicWidth = 9;
  localparam int vmaLoadWidth = 2;

  // Register group, top bit of the function code clear
  localparam logic [memFuncWidth-1:0] memNone = 4'd0;
  localparam logic [memFuncWidth-1:0] memArlInd = 4'd1;
  localparam logic [memFuncWidth-1:0] memMbWait = 4'd2;
  localparam logic [memFuncWidth-1:0] memRestoreVma = 4'd3;
  localparam logic [memFuncWidth-1:0] memARead = 4'd4;
  localparam logic [memFuncWidth-1:0] memBWrite = 4'd5;
  localparam logic [memFuncWidth-1:0] memCondFetch = 4'd6;
  localparam logic [memFuncWidth-1:0] memRegFunc = 4'd7;

  // Cycle group, top bit set
  localparam logic [memFuncWidth-1:0] memAdFunc = 4'd8;
  localparam logic [memFuncWidth-1:0] memEaCalc = 4'd9;
  localparam logic [memFuncWidth-1:0] memLoadAr = 4'd10;
  localparam logic [memFuncWidth-1:0] memLoadArx = 4'd11;
  localparam logic [memFuncWidth-1:0] memRwCycle = 4'd12;
  localparam logic [memFuncWidth-1:0] memRpwCycle = 4'd13;
  localparam logic [memFuncWidth-1:0] memWrite = 4'd14;
  localparam logic [memFuncWidth-1:0] memUncondFetch = 4'd15;

  // Magic field, listed from the top bit down in both views
  typedef union packed {
    struct packed {
      logic prevIndex;
      logic extended;
      logic previous;
      logic userCycle;
      logic kernelCycle;
      logic write;
      logic pause;
      logic loadArx;
      logic loadAr;
    } eaCalcView;
    struct packed {
      logic physRef;
      logic cacheInh;
      logic pcPrev;
      logic eptRef;
      logic uptRef;
      logic mapFunc;
      logic exec;
      logic kernel;
      logic fetch;
    } specMemView;
  } magicWord;

endpackage

/* verilog/pxctControl.sv */
`timescale 1ns/1ps

module pxctControl (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic                   loadSpecInstr,
  input  microwordPkg::magicWord magic,
  input  logic [9:12]            acField,
  input  logic                   eaCalc,
  input  logic                   aRead,
  output logic                   prevEn
);

  logic        pxctFlag;
  logic [9:12] acReg;
  logic [9:12] pxct;

  // Flag and AC held for the whole PXCT instruction
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pxctFlag <= 1'b0;
      acReg <= '0;
    end else if (loadSpecInstr) begin
      pxctFlag <= magic.specMemView.pcPrev;
      acReg <= acField;
    end
  end

  // AC bits only select previous context under PXCT
  assign pxct = pxctFlag ? acReg : '0;

  // Bit 10 for the data operand, 11 for index, 12 for EA words
  assign prevEn = (aRead & pxct[10]) |
                  (eaCalc & magic.eaCalcView.previous & pxct[12]) |
                  (eaCalc & magic.eaCalcView.prevIndex & pxct[11]);

endmodule

/* verilog/refTypeReg.sv */
`timescale 1ns/1ps

module refTypeReg (
  input  logic                                clk,
  input  logic                                arstN,
  input  logic                                reqEn,
  input  logic                                eaCalc,
  input  logic                                adFunc,
  input  logic                                aRead,
  input  logic                                bWrite,
  input  logic                                rwCycle,
  input  logic                                rpwCycle,
  input  logic                                writeFunc,
  input  logic                                loadArFunc,
  input  logic                                loadArxFunc,
  input  logic                                uncondFetch,
  input  logic                                condFetchTaken,
  input  microwordPkg::magicWord              magic,
  input  logic [5:12]                         adHigh,
  input  logic [2:0]                          dramA,
  output logic [memRefPkg::refTypeWidth-1:0]  refType,
  output logic                                vmaFetch
);

  logic [memRefPkg::refTypeWidth-1:0] magicReq;
  logic [memRefPkg::refTypeWidth-1:0] adReq;
  logic [memRefPkg::refTypeWidth-1:0] fixedReq;
  logic                               fetchEn;
  logic                               aReadPause;
  logic                               aReadWrite;

  assign fetchEn = uncondFetch | condFetchTaken | (aRead & (dramA == 3'd1));
  assign aReadPause = aRead & (dramA == 3'd7);
  assign aReadWrite = aRead & ((dramA == 3'd3) | (dramA == 3'd6) | (dramA == 3'd7));

  always_comb begin
    magicReq = '0;
    magicReq[memRefPkg::refLoadAr] = eaCalc & magic.eaCalcView.loadAr;
    magicReq[memRefPkg::refLoadArx] = eaCalc & magic.eaCalcView.loadArx;
    magicReq[memRefPkg::refPause] = eaCalc & magic.eaCalcView.pause;
    magicReq[memRefPkg::refWrite] = eaCalc & magic.eaCalcView.write;
  end

  // Request bits come from AD 9-12 on an AD function
  always_comb begin
    adReq = '0;
    adReq[memRefPkg::refLoadAr] = adFunc & adHigh[9];
    adReq[memRefPkg::refLoadArx] = adFunc & adHigh[10];
    adReq[memRefPkg::refPause] = adFunc & adHigh[11];
    adReq[memRefPkg::refWrite] = adFunc & adHigh[12];
  end

  always_comb begin
    fixedReq = '0;
    fixedReq[memRefPkg::refLoadAr] = loadArFunc | rwCycle | rpwCycle;
    fixedReq[memRefPkg::refLoadArx] = loadArxFunc | fetchEn;
    fixedReq[memRefPkg::refPause] = rpwCycle | aReadPause;
    fixedReq[memRefPkg::refWrite] = writeFunc | bWrite | rwCycle | rpwCycle | aReadWrite;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      refType <= '0;
      vmaFetch <= 1'b0;
    end else if (reqEn) begin
      refType <= magicReq | adReq | fixedReq;
      vmaFetch <= fetchEn;
    end
  end

endmodule

/* verilog/vmaContext.sv */
`timescale 1ns/1ps

module vmaContext (
  input  logic                            clk,
  input  logic                            arstN,
  input  logic                            loadVmaContext,
  input  logic                            eaCalc,
  input  logic                            adFunc,
  input  logic                            regFunc,
  input  microwordPkg::magicWord          magic,
  input  logic [5:12]                     adHigh,
  input  logic                            pcUser,
  input  logic                            pcPublic,
  input  logic                            trapEn,
  input  logic                            cacheLoadEn,
  input  logic                            prevEn,
  output logic [memRefPkg::ctxWidth-1:0]  ctx,
  output logic                            adrErr
);

  logic [memRefPkg::ctxWidth-1:0] ctxNext;
  logic [memRefPkg::ctxWidth-1:0] ctxReg;
  logic [memRefPkg::ctxWidth-1:0] regFuncMask;
  logic                           userEn;
  logic                           publicEn;
  logic                           extEn;
  logic                           adrErrNext;

  // User and public share one rule, only the AD bit differs
  assign userEn = pcUser |
                  (adFunc & adHigh[5]) |
                  (eaCalc & magic.eaCalcView.userCycle);
  assign publicEn = pcPublic |
                    (adFunc & adHigh[6]) |
                    (eaCalc & magic.eaCalcView.userCycle);
  assign extEn = eaCalc & magic.eaCalcView.extended;

  always_comb begin
    ctxNext = '0;
    ctxNext[memRefPkg::ctxUser] = userEn;
    ctxNext[memRefPkg::ctxPublic] = publicEn;
    ctxNext[memRefPkg::ctxPrevious] = prevEn;
    ctxNext[memRefPkg::ctxExtended] = extEn;
    ctxNext[memRefPkg::ctxCache] = ~cacheLoadEn;
    ctxNext[memRefPkg::ctxPaged] = trapEn;
  end

  // Extended address must have AD 6-11 clear
  assign adrErrNext = extEn & (|adHigh[6:11]);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ctxReg <= '0;
      adrErr <= 1'b0;
    end else if (loadVmaContext) begin
      ctxReg <= ctxNext;
      adrErr <= adrErrNext;
    end
  end

  // Register functions run outside user, public and previous context
  always_comb begin
    regFuncMask = '0;
    regFuncMask[memRefPkg::ctxUser] = regFunc;
    regFuncMask[memRefPkg::ctxPublic] = regFunc;
    regFuncMask[memRefPkg::ctxPrevious] = regFunc;
  end

  assign ctx = ctxReg & ~regFuncMask;

endmodule
